// ==== build.f ====
rtl/isa_pkg.sv
rtl/exu_pkg.sv
rtl/exu_disp.sv
rtl/exu_rglr.sv
rtl/exu_brch.sv
rtl/exu_alu.sv
rtl/exu_wbck.sv
rtl/exu_top.sv
tb/exu_properties.sv
tb/exu_tb.sv

// ==== rtl/exu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_alu
    import isa_pkg::*;
    import exu_pkg::*;
(
    input  wire logic            rglr_req,
    input  alu_op_e              rglr_op,
    input  wire logic [xlen-1:0] rglr_in1,
    input  wire logic [xlen-1:0] rglr_in2,

    input  wire logic            brch_req,
    input  alu_op_e              brch_op,
    input  wire logic [xlen-1:0] brch_in1,
    input  wire logic [xlen-1:0] brch_in2,

    output logic [xlen-1:0]      alu_res
);

    alu_op_e              op;
    logic [xlen-1:0]      in1;
    logic [xlen-1:0]      in2;
    logic [shamt_w-1:0]   shamt;

    // regular unit has priority for the ALU
    always_comb begin
        op  = alu_add;
        in1 = '0;
        in2 = '0;
        if (rglr_req) begin
            op  = rglr_op;
            in1 = rglr_in1;
            in2 = rglr_in2;
        end else if (brch_req) begin
            op  = brch_op;
            in1 = brch_in1;
            in2 = brch_in2;
        end
    end

    assign shamt = in2[shamt_w-1:0];

    always_comb begin
        case (op)
            alu_add:   alu_res = in1 + in2;
            alu_sub:   alu_res = in1 - in2;
            alu_and:   alu_res = in1 & in2;
            alu_or:    alu_res = in1 | in2;
            alu_xor:   alu_res = in1 ^ in2;
            alu_sll:   alu_res = in1 << shamt;
            alu_srl:   alu_res = in1 >> shamt;
            alu_sra:   alu_res = $signed(in1) >>> shamt;
            alu_slt:   alu_res = {{(xlen-1){1'b0}}, $signed(in1) < $signed(in2)};
            alu_sltu:  alu_res = {{(xlen-1){1'b0}}, in1 < in2};
            alu_pass2: alu_res = in2;
            default:   alu_res = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/exu_brch.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_brch
    import isa_pkg::*;
    import exu_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            reset,

    input  wire logic            vld,
    input  brch_op_e             op,
    input  wire logic [xlen-1:0] rs1,
    input  wire logic [xlen-1:0] rs2,
    input  wire logic [xlen-1:0] imm,
    input  wire logic [xlen-1:0] pc,

    output logic                 alu_req,
    output alu_op_e              alu_op,
    output logic [xlen-1:0]      alu_in1,
    output logic [xlen-1:0]      alu_in2,
    input  wire logic [xlen-1:0] alu_res,

    output logic                 wbck_vld,
    input  wire logic            wbck_rdy,
    output logic [xlen-1:0]      wbck_wdata,

    output logic                 flush_req,
    input  wire logic            flush_ack,
    output logic [xlen-1:0]      flush_pc_op1,
    output logic [xlen-1:0]      flush_pc_op2,

    output logic                 done
);

    logic is_jump;
    logic taken;
    logic wbck_done_q;
    logic flush_done_q;
    logic wbck_hs;
    logic flush_hs;
    logic wbck_ok;
    logic flush_ok;

    assign is_jump = (op == bop_jal) || (op == bop_jalr);

    // jumps form the link value, branches compare
    always_comb begin
        alu_in1 = rs1;
        alu_in2 = rs2;
        case (op)
            bop_beq, bop_bne:   alu_op = alu_sub;
            bop_blt, bop_bge:   alu_op = alu_slt;
            bop_bltu, bop_bgeu: alu_op = alu_sltu;
            default: begin
                alu_op  = alu_add;
                alu_in1 = pc;
                alu_in2 = xlen'(instr_bytes);
            end
        endcase
    end

    always_comb begin
        case (op)
            bop_beq:            taken = (alu_res == '0);
            bop_bne:            taken = (alu_res != '0);
            bop_blt, bop_bltu:  taken = alu_res[0];
            bop_bge, bop_bgeu:  taken = !alu_res[0];
            default:            taken = 1'b1;
        endcase
    end

    assign alu_req = vld;

    assign wbck_vld   = vld && is_jump && !wbck_done_q;
    assign wbck_wdata = alu_res;

    assign flush_req    = vld && taken && !flush_done_q;
    assign flush_pc_op1 = (op == bop_jalr) ? rs1 : pc;
    assign flush_pc_op2 = imm;

    assign wbck_hs  = wbck_vld && wbck_rdy;
    assign flush_hs = flush_req && flush_ack;

    // each output is either not needed, already through, or finishing now
    assign wbck_ok  = !is_jump || wbck_done_q || wbck_hs;
    assign flush_ok = !taken || flush_done_q || flush_hs;
    assign done     = vld && wbck_ok && flush_ok;

    always_ff @(posedge clk) begin
        if (reset || done) begin
            wbck_done_q  <= 1'b0;
            flush_done_q <= 1'b0;
        end else begin
            if (wbck_hs) begin
                wbck_done_q <= 1'b1;
            end
            if (flush_hs) begin
                flush_done_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exu_disp.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_disp
    import isa_pkg::*;
    import exu_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset,

    input  wire logic                 dec_op_vld,
    output logic                      dec_op_rdy,
    input  exu_unit_e                 dec_unit,
    input  wire logic [dec_op_w-1:0]  dec_op,
    input  wire logic                 dec_use_imm,
    input  wire logic [reg_idx_w-1:0] dec_rd_idx,
    input  wire logic [xlen-1:0]      dec_pc,
    input  wire logic [xlen-1:0]      dec_imm,
    input  wire logic [xlen-1:0]      rs1_rdata,
    input  wire logic [xlen-1:0]      rs2_rdata,

    input  wire logic                 rglr_done,
    input  wire logic                 brch_done,

    output logic                      rglr_vld,
    output logic                      brch_vld,
    output logic [dec_op_w-1:0]       held_op,
    output logic                      held_use_imm,
    output logic [reg_idx_w-1:0]      held_rd_idx,
    output logic [xlen-1:0]           held_pc,
    output logic [xlen-1:0]           held_imm,
    output logic [xlen-1:0]           held_rs1,
    output logic [xlen-1:0]           held_rs2
);

    logic      busy;
    exu_unit_e held_unit;
    logic      retire;
    logic      accept;

    // only the active unit can raise its done
    assign retire     = rglr_done | brch_done;
    assign dec_op_rdy = !busy || retire;
    assign accept     = dec_op_vld && dec_op_rdy;

    assign rglr_vld = busy && (held_unit == unit_rglr);
    assign brch_vld = busy && (held_unit == unit_brch);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (retire) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_unit    <= dec_unit;
            held_op      <= dec_op;
            held_use_imm <= dec_use_imm;
            held_rd_idx  <= dec_rd_idx;
            held_pc      <= dec_pc;
            held_imm     <= dec_imm;
            held_rs1     <= rs1_rdata;
            held_rs2     <= rs2_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    // op field width with the branch opcode in its low bits
    localparam int dec_op_w = 4;

    typedef enum logic [0:0] {
        unit_rglr = 1'b0,
        unit_brch = 1'b1
    } exu_unit_e;

    typedef enum logic [dec_op_w-1:0] {
        rop_add   = 4'd0,
        rop_sub   = 4'd1,
        rop_and   = 4'd2,
        rop_or    = 4'd3,
        rop_xor   = 4'd4,
        rop_sll   = 4'd5,
        rop_srl   = 4'd6,
        rop_sra   = 4'd7,
        rop_slt   = 4'd8,
        rop_sltu  = 4'd9,
        rop_lui   = 4'd10,
        rop_auipc = 4'd11
    } rglr_op_e;

    typedef enum logic [2:0] {
        bop_beq  = 3'd0,
        bop_bne  = 3'd1,
        bop_blt  = 3'd2,
        bop_bge  = 3'd3,
        bop_bltu = 3'd4,
        bop_bgeu = 3'd5,
        bop_jal  = 3'd6,
        bop_jalr = 3'd7
    } brch_op_e;

    typedef enum logic [3:0] {
        alu_add   = 4'd0,
        alu_sub   = 4'd1,
        alu_and   = 4'd2,
        alu_or    = 4'd3,
        alu_xor   = 4'd4,
        alu_sll   = 4'd5,
        alu_srl   = 4'd6,
        alu_sra   = 4'd7,
        alu_slt   = 4'd8,
        alu_sltu  = 4'd9,
        alu_pass2 = 4'd10
    } alu_op_e;

endpackage

`default_nettype wire

// ==== rtl/exu_rglr.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_rglr
    import isa_pkg::*;
    import exu_pkg::*;
(
    input  wire logic            vld,
    input  rglr_op_e             op,
    input  wire logic            use_imm,
    input  wire logic [xlen-1:0] rs1,
    input  wire logic [xlen-1:0] rs2,
    input  wire logic [xlen-1:0] imm,
    input  wire logic [xlen-1:0] pc,

    output logic                 alu_req,
    output alu_op_e              alu_op,
    output logic [xlen-1:0]      alu_in1,
    output logic [xlen-1:0]      alu_in2,
    input  wire logic [xlen-1:0] alu_res,

    output logic                 wbck_vld,
    input  wire logic            wbck_rdy,
    output logic [xlen-1:0]      wbck_wdata,
    output logic                 done
);

    always_comb begin
        alu_in1 = rs1;
        alu_in2 = use_imm ? imm : rs2;
        alu_op  = alu_add;
        case (op)
            rop_add:  alu_op = alu_add;
            rop_sub:  alu_op = alu_sub;
            rop_and:  alu_op = alu_and;
            rop_or:   alu_op = alu_or;
            rop_xor:  alu_op = alu_xor;
            rop_sll:  alu_op = alu_sll;
            rop_srl:  alu_op = alu_srl;
            rop_sra:  alu_op = alu_sra;
            rop_slt:  alu_op = alu_slt;
            rop_sltu: alu_op = alu_sltu;
            rop_lui: begin
                alu_op  = alu_pass2;
                alu_in2 = imm;
            end
            rop_auipc: begin
                alu_op  = alu_add;
                alu_in1 = pc;
                alu_in2 = imm;
            end
            default: alu_op = alu_add;
        endcase
    end

    assign alu_req    = vld;
    assign wbck_vld   = vld;
    assign wbck_wdata = alu_res;
    assign done       = vld && wbck_rdy;

endmodule

`default_nettype wire

// ==== rtl/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top
    import isa_pkg::*;
    import exu_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset,

    input  wire logic                 dec_op_vld,
    output logic                      dec_op_rdy,
    input  exu_unit_e                 dec_unit,
    input  wire logic [dec_op_w-1:0]  dec_op,
    input  wire logic                 dec_use_imm,
    input  wire logic [reg_idx_w-1:0] dec_rd_idx,
    input  wire logic [xlen-1:0]      dec_pc,
    input  wire logic [xlen-1:0]      dec_imm,
    input  wire logic [xlen-1:0]      rs1_rdata,
    input  wire logic [xlen-1:0]      rs2_rdata,

    output logic                      gpr_wbck_vld,
    input  wire logic                 gpr_wbck_rdy,
    output logic [reg_idx_w-1:0]      gpr_wbck_idx,
    output logic [xlen-1:0]           gpr_wbck_wdata,

    output logic                      pipe_flush_req,
    input  wire logic                 pipe_flush_ack,
    output logic [xlen-1:0]           pipe_flush_pc_op1,
    output logic [xlen-1:0]           pipe_flush_pc_op2
);

    logic                 rglr_vld;
    logic                 brch_vld;
    logic                 rglr_done;
    logic                 brch_done;
    logic [dec_op_w-1:0]  held_op;
    logic                 held_use_imm;
    logic [reg_idx_w-1:0] held_rd_idx;
    logic [xlen-1:0]      held_pc;
    logic [xlen-1:0]      held_imm;
    logic [xlen-1:0]      held_rs1;
    logic [xlen-1:0]      held_rs2;

    logic                 rglr2alu_req;
    alu_op_e              rglr2alu_op;
    logic [xlen-1:0]      rglr2alu_in1;
    logic [xlen-1:0]      rglr2alu_in2;
    logic                 brch2alu_req;
    alu_op_e              brch2alu_op;
    logic [xlen-1:0]      brch2alu_in1;
    logic [xlen-1:0]      brch2alu_in2;
    logic [xlen-1:0]      alu_res;

    logic                 rglr2wbck_vld;
    logic                 rglr2wbck_rdy;
    logic [xlen-1:0]      rglr2wbck_wdata;
    logic                 brch2wbck_vld;
    logic                 brch2wbck_rdy;
    logic [xlen-1:0]      brch2wbck_wdata;

    exu_disp u_disp (
        .clk          (clk),
        .reset        (reset),
        .dec_op_vld   (dec_op_vld),
        .dec_op_rdy   (dec_op_rdy),
        .dec_unit     (dec_unit),
        .dec_op       (dec_op),
        .dec_use_imm  (dec_use_imm),
        .dec_rd_idx   (dec_rd_idx),
        .dec_pc       (dec_pc),
        .dec_imm      (dec_imm),
        .rs1_rdata    (rs1_rdata),
        .rs2_rdata    (rs2_rdata),
        .rglr_done    (rglr_done),
        .brch_done    (brch_done),
        .rglr_vld     (rglr_vld),
        .brch_vld     (brch_vld),
        .held_op      (held_op),
        .held_use_imm (held_use_imm),
        .held_rd_idx  (held_rd_idx),
        .held_pc      (held_pc),
        .held_imm     (held_imm),
        .held_rs1     (held_rs1),
        .held_rs2     (held_rs2)
    );

    exu_rglr u_rglr (
        .vld        (rglr_vld),
        .op         (rglr_op_e'(held_op)),
        .use_imm    (held_use_imm),
        .rs1        (held_rs1),
        .rs2        (held_rs2),
        .imm        (held_imm),
        .pc         (held_pc),
        .alu_req    (rglr2alu_req),
        .alu_op     (rglr2alu_op),
        .alu_in1    (rglr2alu_in1),
        .alu_in2    (rglr2alu_in2),
        .alu_res    (alu_res),
        .wbck_vld   (rglr2wbck_vld),
        .wbck_rdy   (rglr2wbck_rdy),
        .wbck_wdata (rglr2wbck_wdata),
        .done       (rglr_done)
    );

    exu_brch u_brch (
        .clk          (clk),
        .reset        (reset),
        .vld          (brch_vld),
        .op           (brch_op_e'(held_op[2:0])),
        .rs1          (held_rs1),
        .rs2          (held_rs2),
        .imm          (held_imm),
        .pc           (held_pc),
        .alu_req      (brch2alu_req),
        .alu_op       (brch2alu_op),
        .alu_in1      (brch2alu_in1),
        .alu_in2      (brch2alu_in2),
        .alu_res      (alu_res),
        .wbck_vld     (brch2wbck_vld),
        .wbck_rdy     (brch2wbck_rdy),
        .wbck_wdata   (brch2wbck_wdata),
        .flush_req    (pipe_flush_req),
        .flush_ack    (pipe_flush_ack),
        .flush_pc_op1 (pipe_flush_pc_op1),
        .flush_pc_op2 (pipe_flush_pc_op2),
        .done         (brch_done)
    );

    // one ALU shared by both units
    exu_alu u_alu (
        .rglr_req (rglr2alu_req),
        .rglr_op  (rglr2alu_op),
        .rglr_in1 (rglr2alu_in1),
        .rglr_in2 (rglr2alu_in2),
        .brch_req (brch2alu_req),
        .brch_op  (brch2alu_op),
        .brch_in1 (brch2alu_in1),
        .brch_in2 (brch2alu_in2),
        .alu_res  (alu_res)
    );

    exu_wbck u_wbck (
        .rglr_vld       (rglr2wbck_vld),
        .rglr_wdata     (rglr2wbck_wdata),
        .rglr_rdy       (rglr2wbck_rdy),
        .brch_vld       (brch2wbck_vld),
        .brch_wdata     (brch2wbck_wdata),
        .brch_rdy       (brch2wbck_rdy),
        .rd_idx         (held_rd_idx),
        .gpr_wbck_vld   (gpr_wbck_vld),
        .gpr_wbck_rdy   (gpr_wbck_rdy),
        .gpr_wbck_idx   (gpr_wbck_idx),
        .gpr_wbck_wdata (gpr_wbck_wdata)
    );

endmodule

`default_nettype wire

// ==== rtl/exu_wbck.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_wbck
    import isa_pkg::*;
(
    input  wire logic                 rglr_vld,
    input  wire logic [xlen-1:0]      rglr_wdata,
    output logic                      rglr_rdy,

    input  wire logic                 brch_vld,
    input  wire logic [xlen-1:0]      brch_wdata,
    output logic                      brch_rdy,

    input  wire logic [reg_idx_w-1:0] rd_idx,

    output logic                      gpr_wbck_vld,
    input  wire logic                 gpr_wbck_rdy,
    output logic [reg_idx_w-1:0]      gpr_wbck_idx,
    output logic [xlen-1:0]           gpr_wbck_wdata
);

    // at most one unit holds an instruction at a time
    assign gpr_wbck_vld   = rglr_vld || brch_vld;
    assign gpr_wbck_wdata = rglr_vld ? rglr_wdata : brch_wdata;
    assign gpr_wbck_idx   = rd_idx;

    assign rglr_rdy = gpr_wbck_rdy && rglr_vld;
    assign brch_rdy = gpr_wbck_rdy && brch_vld;

endmodule

`default_nettype wire

// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // RV32I data and address width
    localparam int xlen = 32;

    // register file index
    localparam int reg_idx_w = 5;

    // pc step for a 32-bit instruction
    localparam int instr_bytes = 4;

    // shift amount taken from the second operand
    localparam int shamt_w = 5;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
verilator --binary --timing --assert -f build.f --top-module exu_tb -o exu_sim \
    && ./obj_dir/exu_sim | tee /dev/stderr | grep -q "^Testbench passed$" \
    && echo "run ok" \
    || { echo "run reported failure"; exit 1; }

// ==== tb/exu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_properties
    import isa_pkg::*;
(
    input wire logic                 clk,
    input wire logic                 reset,
    input wire logic                 gpr_wbck_vld,
    input wire logic                 gpr_wbck_rdy,
    input wire logic [reg_idx_w-1:0] gpr_wbck_idx,
    input wire logic [xlen-1:0]      gpr_wbck_wdata,
    input wire logic                 pipe_flush_req,
    input wire logic                 pipe_flush_ack,
    input wire logic [xlen-1:0]      pipe_flush_pc_op1,
    input wire logic [xlen-1:0]      pipe_flush_pc_op2
);

    // a stalled writeback keeps its payload
    wbck_hold: assert property (@(posedge clk) disable iff (reset)
        gpr_wbck_vld && !gpr_wbck_rdy |=>
            gpr_wbck_vld && $stable(gpr_wbck_idx) && $stable(gpr_wbck_wdata))
        else $error("writeback valid or data changed while stalled");

    // flush request held with its operands until ack
    flush_hold: assert property (@(posedge clk) disable iff (reset)
        pipe_flush_req && !pipe_flush_ack |=>
            pipe_flush_req && $stable(pipe_flush_pc_op1) && $stable(pipe_flush_pc_op2))
        else $error("flush request or operands changed before ack");

    reset_quiet: assert property (@(posedge clk)
        reset && $past(reset) |-> !gpr_wbck_vld && !pipe_flush_req)
        else $error("writeback or flush active during reset");

endmodule

bind exu_top exu_properties u_props (
    .clk               (clk),
    .reset             (reset),
    .gpr_wbck_vld      (gpr_wbck_vld),
    .gpr_wbck_rdy      (gpr_wbck_rdy),
    .gpr_wbck_idx      (gpr_wbck_idx),
    .gpr_wbck_wdata    (gpr_wbck_wdata),
    .pipe_flush_req    (pipe_flush_req),
    .pipe_flush_ack    (pipe_flush_ack),
    .pipe_flush_pc_op1 (pipe_flush_pc_op1),
    .pipe_flush_pc_op2 (pipe_flush_pc_op2)
);

`default_nettype wire

// ==== tb/exu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_tb
    import isa_pkg::*;
    import exu_pkg::*;
;

    localparam int kind_reg   = 0;
    localparam int kind_imm   = 1;
    localparam int kind_brch  = 2;
    localparam int kind_jump  = 3;
    localparam int kind_mixed = 4;

    localparam int n_reg   = 60;
    localparam int n_imm   = 60;
    localparam int n_brch  = 80;
    localparam int n_jump  = 40;
    localparam int n_mixed = 120;
    localparam int n_total = n_reg + n_imm + n_brch + n_jump + n_mixed;
    localparam int timeout_cycles = n_total * 20 + 100;

    logic                 clk;
    logic                 reset;
    logic                 dec_op_vld;
    logic                 dec_op_rdy;
    exu_unit_e            dec_unit;
    logic [dec_op_w-1:0]  dec_op;
    logic                 dec_use_imm;
    logic [reg_idx_w-1:0] dec_rd_idx;
    logic [xlen-1:0]      dec_pc;
    logic [xlen-1:0]      dec_imm;
    logic [xlen-1:0]      rs1_rdata;
    logic [xlen-1:0]      rs2_rdata;
    logic                 gpr_wbck_vld;
    logic                 gpr_wbck_rdy;
    logic [reg_idx_w-1:0] gpr_wbck_idx;
    logic [xlen-1:0]      gpr_wbck_wdata;
    logic                 pipe_flush_req;
    logic                 pipe_flush_ack;
    logic [xlen-1:0]      pipe_flush_pc_op1;
    logic [xlen-1:0]      pipe_flush_pc_op2;

    // expected outputs in issue order
    logic [reg_idx_w+xlen-1:0] wbck_q[$];
    logic [2*xlen-1:0]         flush_q[$];

    string cur_test;
    int    test_errs;
    int    errors;
    int    checks;
    int    cycles;

    exu_top UUT (
        .clk               (clk),
        .reset             (reset),
        .dec_op_vld        (dec_op_vld),
        .dec_op_rdy        (dec_op_rdy),
        .dec_unit          (dec_unit),
        .dec_op            (dec_op),
        .dec_use_imm       (dec_use_imm),
        .dec_rd_idx        (dec_rd_idx),
        .dec_pc            (dec_pc),
        .dec_imm           (dec_imm),
        .rs1_rdata         (rs1_rdata),
        .rs2_rdata         (rs2_rdata),
        .gpr_wbck_vld      (gpr_wbck_vld),
        .gpr_wbck_rdy      (gpr_wbck_rdy),
        .gpr_wbck_idx      (gpr_wbck_idx),
        .gpr_wbck_wdata    (gpr_wbck_wdata),
        .pipe_flush_req    (pipe_flush_req),
        .pipe_flush_ack    (pipe_flush_ack),
        .pipe_flush_pc_op1 (pipe_flush_pc_op1),
        .pipe_flush_pc_op2 (pipe_flush_pc_op2)
    );

    always #20 clk = ~clk;

    function automatic logic [xlen-1:0] rglr_expect(logic [3:0] op, logic use_imm,
            logic [xlen-1:0] a, logic [xlen-1:0] b, logic [xlen-1:0] imm,
            logic [xlen-1:0] pc);
        logic [xlen-1:0] y;
        y = use_imm ? imm : b;
        case (rglr_op_e'(op))
            rop_add:   return a + y;
            rop_sub:   return a - y;
            rop_and:   return a & y;
            rop_or:    return a | y;
            rop_xor:   return a ^ y;
            rop_sll:   return a << y[4:0];
            rop_srl:   return a >> y[4:0];
            rop_sra:   return $signed(a) >>> y[4:0];
            rop_slt:   return ($signed(a) < $signed(y)) ? 32'd1 : 32'd0;
            rop_sltu:  return (a < y) ? 32'd1 : 32'd0;
            rop_lui:   return imm;
            rop_auipc: return pc + imm;
            default:   return 32'd0;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] op, logic [xlen-1:0] a,
            logic [xlen-1:0] b);
        case (brch_op_e'(op))
            bop_beq:  return a == b;
            bop_bne:  return a != b;
            bop_blt:  return $signed(a) < $signed(b);
            bop_bge:  return !($signed(a) < $signed(b));
            bop_bltu: return a < b;
            bop_bgeu: return !(a < b);
            default:  return 1'b1;
        endcase
    endfunction

    // back-pressure on both outputs
    always @(negedge clk) begin
        gpr_wbck_rdy   = ($urandom_range(0, 3) != 0);
        pipe_flush_ack = ($urandom_range(0, 2) != 0);
    end

    // compares handshakes seen at the rising edge against the queues
    always @(posedge clk) begin
        logic [reg_idx_w+xlen-1:0] w;
        logic [2*xlen-1:0]         f;
        if (!reset && gpr_wbck_vld && gpr_wbck_rdy) begin
            checks = checks + 1;
            if (wbck_q.size() == 0) begin
                $display("%s: writeback seen with no instruction expecting one", cur_test);
                errors = errors + 1;
                test_errs = test_errs + 1;
            end else begin
                w = wbck_q.pop_front();
                if (w !== {gpr_wbck_idx, gpr_wbck_wdata}) begin
                    $display("ERR %s wbck idx/data expected %0d/%h actual %0d/%h", cur_test,
                        w[reg_idx_w+xlen-1:xlen], w[xlen-1:0], gpr_wbck_idx, gpr_wbck_wdata);
                    errors = errors + 1;
                    test_errs = test_errs + 1;
                end
            end
        end
        if (!reset && pipe_flush_req && pipe_flush_ack) begin
            checks = checks + 1;
            if (flush_q.size() == 0) begin
                $display("%s: flush seen with no instruction expecting one", cur_test);
                errors = errors + 1;
                test_errs = test_errs + 1;
            end else begin
                f = flush_q.pop_front();
                if (f !== {pipe_flush_pc_op1, pipe_flush_pc_op2}) begin
                    $display("ERR %s flush op1/op2 expected %h/%h actual %h/%h", cur_test,
                        f[2*xlen-1:xlen], f[xlen-1:0], pipe_flush_pc_op1, pipe_flush_pc_op2);
                    errors = errors + 1;
                    test_errs = test_errs + 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_cycles) begin
            $display("run timed out after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // builds one random instruction, waits for acceptance, queues its outputs
    task automatic issue_random(input int kind);
        exu_unit_e            unit;
        logic [3:0]           op;
        logic                 use_imm;
        logic [xlen-1:0]      pc;
        logic [xlen-1:0]      imm;
        logic [xlen-1:0]      a;
        logic [xlen-1:0]      b;
        logic [reg_idx_w-1:0] rd;
        int                   k;
        int                   gap;
        k = (kind == kind_mixed) ? int'($urandom_range(0, 3)) : kind;
        unit    = unit_brch;
        use_imm = 1'b0;
        case (k)
            kind_reg: begin
                unit = unit_rglr;
                op   = 4'($urandom_range(0, 9));
            end
            kind_imm: begin
                unit    = unit_rglr;
                use_imm = 1'b1;
                op      = 4'($urandom_range(0, 11));
            end
            kind_brch: op = 4'($urandom_range(0, 5));
            default:   op = 4'($urandom_range(6, 7));
        endcase
        pc  = $urandom & 32'hffff_fffc;
        imm = $urandom;
        if ($urandom_range(0, 1) == 0) begin
            imm = {{20{imm[11]}}, imm[11:0]};
        end
        a = $urandom;
        b = $urandom;
        // equal operands make beq and bge style branches go taken
        if ($urandom_range(0, 2) == 0) begin
            b = a;
        end
        rd  = reg_idx_w'($urandom);
        gap = $urandom_range(0, 2);
        repeat (gap) @(negedge clk);
        dec_unit    = unit;
        dec_op      = op;
        dec_use_imm = use_imm;
        dec_rd_idx  = rd;
        dec_pc      = pc;
        dec_imm     = imm;
        rs1_rdata   = a;
        rs2_rdata   = b;
        dec_op_vld  = 1'b1;
        @(posedge clk);
        while (!dec_op_rdy) @(posedge clk);
        if (unit == unit_rglr) begin
            wbck_q.push_back({rd, rglr_expect(op, use_imm, a, b, imm, pc)});
        end else if (op[2:0] == bop_jal || op[2:0] == bop_jalr) begin
            wbck_q.push_back({rd, pc + 32'd4});
            flush_q.push_back({(op[2:0] == bop_jalr) ? a : pc, imm});
        end else if (branch_taken(op[2:0], a, b)) begin
            flush_q.push_back({pc, imm});
        end
        @(negedge clk);
        dec_op_vld = 1'b0;
    endtask

    task automatic run_test(input string name, input int kind, input int count);
        cur_test  = name;
        test_errs = 0;
        for (int i = 0; i < count; i++) begin
            issue_random(kind);
        end
        while (wbck_q.size() != 0 || flush_q.size() != 0) @(posedge clk);
        @(negedge clk);
        $display("%s: %0d instructions, %0d errors", name, count, test_errs);
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        dec_op_vld     = 1'b0;
        dec_unit       = unit_rglr;
        dec_op         = '0;
        dec_use_imm    = 1'b0;
        dec_rd_idx     = '0;
        dec_pc         = '0;
        dec_imm        = '0;
        rs1_rdata      = '0;
        rs2_rdata      = '0;
        gpr_wbck_rdy   = 1'b0;
        pipe_flush_ack = 1'b0;
        errors         = 0;
        checks         = 0;
        cycles         = 0;
        void'($urandom(29672));
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        cur_test  = "reset";
        test_errs = 0;
        repeat (4) begin
            @(posedge clk);
            checks = checks + 1;
            if (!dec_op_rdy || gpr_wbck_vld || pipe_flush_req) begin
                $display("reset: ready low or output active before any instruction");
                errors = errors + 1;
                test_errs = test_errs + 1;
            end
        end
        @(negedge clk);
        $display("reset: %0d errors", test_errs);

        run_test("rglr_reg", kind_reg, n_reg);
        run_test("rglr_imm", kind_imm, n_imm);
        run_test("branch", kind_brch, n_brch);
        run_test("jump", kind_jump, n_jump);
        run_test("mixed", kind_mixed, n_mixed);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
